// ==== Makefile ====
TOP := cache_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== cache_array_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

interface cache_array_if;
	import cache_pkg::*;

	// set read, issued by the controller
	logic lookup_en;
	logic [`CACHE_INDEX_W-1:0] lookup_index;

	// store hit write
	logic st_en;
	cache_way_t st_way;
	logic [$clog2(`CACHE_BEATS)-1:0] st_word;
	logic [`CACHE_STRB_W-1:0] st_strb;
	cache_word_t st_data;

	// refill beat write
	logic fill_en;
	cache_way_t fill_way;
	logic [$clog2(`CACHE_BEATS)-1:0] fill_word;
	cache_word_t fill_data;
	logic [`CACHE_TAG_W-1:0] fill_tag;
	logic fill_dirty;

	// registered read of the looked-up set
	logic [`CACHE_TAG_W-1:0] rd_tag [`CACHE_WAYS];
	logic rd_valid [`CACHE_WAYS];
	logic rd_dirty [`CACHE_WAYS];
	cache_word_t rd_data [`CACHE_WAYS][`CACHE_BEATS];
	cache_way_t victim_way;

	modport ctrl (
		output lookup_en, lookup_index, st_en, st_way, st_word, st_strb, st_data,
		input rd_tag, rd_valid, rd_dirty, rd_data, victim_way
	);

	modport refill (
		output fill_en, fill_way, fill_word, fill_data, fill_tag, fill_dirty
	);

	modport storage (
		input lookup_en, lookup_index, st_en, st_way, st_word, st_strb, st_data,
		input fill_en, fill_way, fill_word, fill_data, fill_tag, fill_dirty,
		output rd_tag, rd_valid, rd_dirty, rd_data, victim_way
	);

endinterface

`default_nettype wire

// ==== cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split: tag | index | offset
`define CACHE_TAG_W 8
`define CACHE_INDEX_W 4
`define CACHE_OFFSET_W 4

// data path
`define CACHE_WORD_W 64
`define CACHE_STRB_W 8

// line geometry
`define CACHE_BEATS 2
`define CACHE_WAYS 2

`endif

// ==== cache_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input cache_pkg::cache_op_e req_op,
	input wire logic [`CACHE_TAG_W-1:0] req_tag,
	input wire logic [`CACHE_INDEX_W-1:0] req_index,
	input wire logic [`CACHE_OFFSET_W-1:0] req_offset,
	input wire logic [`CACHE_STRB_W-1:0] req_wstrb,
	input wire logic [`CACHE_WORD_W-1:0] req_wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::cache_word_t rdata,
	output logic wb_req,
	output mem_pkg::mem_line_addr_t wb_addr,
	output mem_pkg::mem_line_t wb_data,
	output cache_pkg::cache_req_t miss_req,
	output cache_pkg::cache_way_t miss_way,
	output logic refill_start,
	input wire logic refill_done,
	input cache_pkg::cache_word_t miss_word,
	cache_array_if.ctrl arr
);
	import cache_pkg::*;

	localparam int WSEL_W = $clog2(`CACHE_BEATS);

	cache_state_e state;
	cache_state_e next_state;
	cache_req_t req_q;
	// hit way on a store hit, victim way on a miss
	cache_way_t way_q;
	logic hit;
	cache_way_t hit_way;
	cache_word_t hit_word;

	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (arr.rd_valid[w] && arr.rd_tag[w] == req_q.tag) begin
				hit = 1'b1;
				hit_way = cache_way_t'(w);
			end
		end
	end

	assign hit_word = arr.rd_data[hit_way][req_q.word];

	always_comb begin
		next_state = state;
		addr_ok = 1'b0;
		data_ok = 1'b0;
		arr.lookup_en = 1'b0;
		arr.st_en = 1'b0;
		wb_req = 1'b0;
		refill_start = 1'b0;
		case (state)
			ST_IDLE: begin
				addr_ok = 1'b1;
				if (req_valid) begin
					arr.lookup_en = 1'b1;
					next_state = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				if (hit) begin
					data_ok = 1'b1;
					next_state = (req_q.op == OP_WRITE) ? ST_WRITE : ST_IDLE;
				end else begin
					next_state = ST_MISS;
				end
			end
			ST_WRITE: begin
				arr.st_en = 1'b1;
				next_state = ST_IDLE;
			end
			ST_MISS: begin
				// write-back and line read go out together
				wb_req = arr.rd_valid[way_q] && arr.rd_dirty[way_q];
				refill_start = 1'b1;
				next_state = ST_REFILL;
			end
			ST_REFILL: begin
				if (refill_done) begin
					data_ok = 1'b1;
					next_state = ST_IDLE;
				end
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) begin
			req_q.op <= req_op;
			req_q.tag <= req_tag;
			req_q.index <= req_index;
			req_q.word <= req_offset[`CACHE_OFFSET_W-1 -: WSEL_W];
			req_q.strb <= req_wstrb;
			req_q.wdata <= req_wdata;
		end
		if (state == ST_LOOKUP) begin
			way_q <= hit ? hit_way : arr.victim_way;
		end
	end

	assign arr.lookup_index = req_index;
	assign arr.st_way = way_q;
	assign arr.st_word = req_q.word;
	assign arr.st_strb = req_q.strb;
	assign arr.st_data = req_q.wdata;

	// victim line still sits in the read registers during ST_MISS
	assign wb_addr = {arr.rd_tag[way_q], req_q.index};
	always_comb begin
		for (int b = 0; b < `CACHE_BEATS; b++) begin
			wb_data[b*`CACHE_WORD_W +: `CACHE_WORD_W] = arr.rd_data[way_q][b];
		end
	end

	assign rdata = (state == ST_LOOKUP) ? hit_word : miss_word;
	assign miss_req = req_q;
	assign miss_way = way_q;

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cache_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITE,
		ST_MISS,
		ST_REFILL
	} cache_state_e;

	typedef logic [`CACHE_WORD_W-1:0] cache_word_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] cache_way_t;

	// latched processor request
	typedef struct packed {
		cache_op_e op;
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [$clog2(`CACHE_BEATS)-1:0] word;
		logic [`CACHE_STRB_W-1:0] strb;
		cache_word_t wdata;
	} cache_req_t;

endpackage

`default_nettype wire

// ==== cache_refill.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_refill (
	input wire logic clk,
	input wire logic rst,
	input wire logic refill_start,
	input cache_pkg::cache_req_t miss_req,
	input cache_pkg::cache_way_t miss_way,
	output logic rd_req,
	output mem_pkg::mem_line_addr_t rd_addr,
	input wire logic rd_beat_valid,
	input wire logic rd_last,
	input cache_pkg::cache_word_t rd_data,
	output logic refill_done,
	output cache_pkg::cache_word_t miss_word,
	cache_array_if.refill arr
);
	import cache_pkg::*;

	logic busy;
	logic beat;
	logic [$clog2(`CACHE_BEATS)-1:0] beat_cnt;
	logic done_q;
	cache_word_t word_q;
	cache_word_t merged;

	assign rd_req = refill_start;
	assign rd_addr = {miss_req.tag, miss_req.index};
	assign beat = busy && rd_beat_valid;

	// store bytes replace memory bytes in the targeted beat
	always_comb begin
		merged = rd_data;
		if (miss_req.op == OP_WRITE && beat_cnt == miss_req.word) begin
			for (int i = 0; i < `CACHE_STRB_W; i++) begin
				if (miss_req.strb[i]) begin
					merged[i*8 +: 8] = miss_req.wdata[i*8 +: 8];
				end
			end
		end
	end

	assign arr.fill_en = beat;
	assign arr.fill_way = miss_way;
	assign arr.fill_word = beat_cnt;
	assign arr.fill_data = merged;
	assign arr.fill_tag = miss_req.tag;
	assign arr.fill_dirty = (miss_req.op == OP_WRITE);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			beat_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= beat && rd_last;
			if (refill_start) begin
				busy <= 1'b1;
				beat_cnt <= '0;
			end else if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (rd_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// requested word, held for the controller
	always_ff @(posedge clk) begin
		if (beat && beat_cnt == miss_req.word) begin
			word_q <= merged;
		end
	end

	assign refill_done = done_q;
	assign miss_word = word_q;

endmodule

`default_nettype wire

// ==== cache_storage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_storage (
	input wire logic clk,
	input wire logic rst,
	cache_array_if.storage arr
);
	import cache_pkg::*;

	localparam int SETS = 1 << `CACHE_INDEX_W;

	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_WAYS][SETS];
	cache_word_t data_mem [`CACHE_WAYS][`CACHE_BEATS][SETS];
	logic [SETS-1:0] valid [`CACHE_WAYS];
	logic [SETS-1:0] dirty [`CACHE_WAYS];
	cache_way_t vptr [SETS];

	// index of the set in flight, writes go here
	logic [`CACHE_INDEX_W-1:0] cur_index;
	cache_way_t rd_ptr;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
			for (int s = 0; s < SETS; s++) begin
				vptr[s] <= '0;
			end
		end else begin
			if (arr.st_en) begin
				dirty[arr.st_way][cur_index] <= 1'b1;
			end
			if (arr.fill_en) begin
				valid[arr.fill_way][cur_index] <= 1'b1;
				dirty[arr.fill_way][cur_index] <= arr.fill_dirty;
				// last beat of the line moves the round-robin pointer
				if (arr.fill_word == ($clog2(`CACHE_BEATS))'(`CACHE_BEATS - 1)) begin
					vptr[cur_index] <= vptr[cur_index] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arr.lookup_en) begin
			cur_index <= arr.lookup_index;
			rd_ptr <= vptr[arr.lookup_index];
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				arr.rd_tag[w] <= tag_mem[w][arr.lookup_index];
				arr.rd_valid[w] <= valid[w][arr.lookup_index];
				arr.rd_dirty[w] <= dirty[w][arr.lookup_index];
				for (int b = 0; b < `CACHE_BEATS; b++) begin
					arr.rd_data[w][b] <= data_mem[w][b][arr.lookup_index];
				end
			end
		end
		if (arr.fill_en) begin
			tag_mem[arr.fill_way][cur_index] <= arr.fill_tag;
			data_mem[arr.fill_way][arr.fill_word][cur_index] <= arr.fill_data;
		end
		// byte-strobed store hit
		if (arr.st_en) begin
			for (int i = 0; i < `CACHE_STRB_W; i++) begin
				if (arr.st_strb[i]) begin
					data_mem[arr.st_way][arr.st_word][cur_index][i*8 +: 8] <= arr.st_data[i*8 +: 8];
				end
			end
		end
	end

	// invalid way wins, lowest first, else the pointer
	always_comb begin
		arr.victim_way = rd_ptr;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!arr.rd_valid[w]) begin
				arr.victim_way = cache_way_t'(w);
			end
		end
	end

endmodule

`default_nettype wire

// ==== cache_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire logic addr_ok,
	input wire logic data_ok,
	input wire logic rd_req,
	input wire logic wb_req
);

	int unsigned fail_count = 0;

	// one line read per miss
	rd_req_single: assert property (@(posedge clk) disable iff (rst) rd_req |=> !rd_req)
		else begin
			$error("rd_req high in two consecutive cycles");
			fail_count++;
		end

	// one write-back per eviction
	wb_req_single: assert property (@(posedge clk) disable iff (rst) wb_req |=> !wb_req)
		else begin
			$error("wb_req high in two consecutive cycles");
			fail_count++;
		end

	// idle never completes a request
	data_ok_busy: assert property (@(posedge clk) disable iff (rst) !(data_ok && addr_ok))
		else begin
			$error("data_ok while addr_ok is high");
			fail_count++;
		end

	req_only_idle: assert property (@(posedge clk) disable iff (rst) req_valid |-> addr_ok)
		else begin
			$error("req_valid while addr_ok is low");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== cache_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_tb;
	import cache_pkg::*;
	import mem_pkg::*;

	localparam int CLK_NS = 10;
	localparam int REQ_BUDGET = 40;
	localparam int TEST_REQS = 12;
	localparam int WATCHDOG_NS = (8 + TEST_REQS * REQ_BUDGET) * CLK_NS;

	logic clk;
	logic rst;
	logic req_valid;
	cache_op_e req_op;
	logic [`CACHE_TAG_W-1:0] req_tag;
	logic [`CACHE_INDEX_W-1:0] req_index;
	logic [`CACHE_OFFSET_W-1:0] req_offset;
	logic [`CACHE_STRB_W-1:0] req_wstrb;
	cache_word_t req_wdata;
	logic addr_ok;
	logic data_ok;
	cache_word_t rdata;
	logic rd_req;
	mem_line_addr_t rd_addr;
	logic rd_beat_valid;
	logic rd_last;
	cache_word_t rd_data;
	logic wb_req;
	mem_line_addr_t wb_addr;
	mem_line_t wb_data;

	// memory model contents and bus activity
	mem_line_t lines [mem_line_addr_t];
	int rd_count = 0;
	int wb_count = 0;
	mem_line_addr_t last_rd_addr;
	mem_line_addr_t last_wb_addr;
	mem_line_t last_wb_data;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) clkgen_inst (.clk(clk), .rst(rst));

	cache_top cache_top_inst (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req_op        (req_op),
		.req_tag       (req_tag),
		.req_index     (req_index),
		.req_offset    (req_offset),
		.req_wstrb     (req_wstrb),
		.req_wdata     (req_wdata),
		.addr_ok       (addr_ok),
		.data_ok       (data_ok),
		.rdata         (rdata),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_beat_valid (rd_beat_valid),
		.rd_last       (rd_last),
		.rd_data       (rd_data),
		.wb_req        (wb_req),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data)
	);

	bind cache_top cache_sva cache_sva_inst (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.addr_ok   (addr_ok),
		.data_ok   (data_ok),
		.rd_req    (rd_req),
		.wb_req    (wb_req)
	);

	// unwritten memory derived from line address and word
	function automatic cache_word_t pattern_word(input mem_line_addr_t addr, input int w);
		logic [3:0] ws;
		ws = 4'(w);
		return {addr, ws, 16'hbeef, ~addr, ws, 16'h1234};
	endfunction

	function automatic cache_word_t merge_bytes(input cache_word_t old_word,
			input cache_word_t new_word, input logic [`CACHE_STRB_W-1:0] strb);
		cache_word_t res;
		res = old_word;
		for (int i = 0; i < `CACHE_STRB_W; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic mem_line_t model_line(input mem_line_addr_t addr);
		mem_line_t line;
		if (lines.exists(addr)) begin
			return lines[addr];
		end
		for (int w = 0; w < `CACHE_BEATS; w++) begin
			line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = pattern_word(addr, w);
		end
		return line;
	endfunction

	task automatic check_word(input cache_word_t got, input cache_word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_line(input mem_line_t got, input mem_line_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input mem_line_addr_t got, input mem_line_addr_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// first beat 1 to 4 cycles after rd_req with random gaps between beats
	task automatic serve_read(input mem_line_addr_t addr);
		int unsigned delay;
		int unsigned gap;
		mem_line_t line;
		line = model_line(addr);
		delay = $urandom_range(4, 1);
		repeat (delay - 1) @(posedge clk);
		for (int w = 0; w < `CACHE_BEATS; w++) begin
			gap = $urandom_range(1, 0);
			@(posedge clk);
			if (w > 0 && gap != 0) begin
				rd_beat_valid <= 1'b0;
				rd_last <= 1'b0;
				@(posedge clk);
			end
			rd_beat_valid <= 1'b1;
			rd_data <= line[w*`CACHE_WORD_W +: `CACHE_WORD_W];
			rd_last <= (w == `CACHE_BEATS - 1);
		end
		@(posedge clk);
		rd_beat_valid <= 1'b0;
		rd_last <= 1'b0;
	endtask

	initial begin : mem_model
		void'($urandom(32'hf4b1dc16));
		rd_beat_valid <= 1'b0;
		rd_last <= 1'b0;
		rd_data <= '0;
		forever begin
			@(negedge clk);
			if (rd_req) begin
				serve_read(rd_addr);
			end
		end
	end

	// write-backs land in the model at once
	always @(negedge clk) begin
		if (rd_req) begin
			rd_count++;
			last_rd_addr = rd_addr;
		end
		if (wb_req) begin
			wb_count++;
			last_wb_addr = wb_addr;
			last_wb_data = wb_data;
			lines[wb_addr] = wb_data;
		end
	end

	// latency counts cycles from acceptance to data_ok
	task automatic send_req(input cache_op_e op, input logic [`CACHE_TAG_W-1:0] tag,
			input logic [`CACHE_INDEX_W-1:0] index, input logic [`CACHE_OFFSET_W-1:0] offset,
			input logic [`CACHE_STRB_W-1:0] strb, input cache_word_t wdata,
			output cache_word_t data, output int latency);
		int cycles;
		@(negedge clk);
		while (!addr_ok) begin
			@(negedge clk);
		end
		@(posedge clk);
		req_valid <= 1'b1;
		req_op <= op;
		req_tag <= tag;
		req_index <= index;
		req_offset <= offset;
		req_wstrb <= strb;
		req_wdata <= wdata;
		@(posedge clk);
		req_valid <= 1'b0;
		cycles = 1;
		@(negedge clk);
		while (!data_ok && cycles < REQ_BUDGET) begin
			cycles++;
			@(negedge clk);
		end
		data = rdata;
		latency = cycles;
		if (!data_ok) begin
			timeouts++;
			latency = -1;
			$display("no data_ok within %0d cycles of the request, time %0t", REQ_BUDGET, $time);
		end
	endtask

	task automatic idle_after_reset();
		@(negedge clk);
		while (rst) begin
			@(negedge clk);
		end
		@(negedge clk);
		check_bit(addr_ok, 1'b1, "addr_ok after reset");
		check_bit(data_ok, 1'b0, "data_ok after reset");
		check_bit(rd_req, 1'b0, "rd_req after reset");
		check_bit(wb_req, 1'b0, "wb_req after reset");
	endtask

	task automatic read_miss_alloc();
		cache_word_t data;
		int lat;
		int rd0;
		int wb0;
		mem_line_addr_t a;
		a = {8'h12, 4'h3};
		rd0 = rd_count;
		wb0 = wb_count;
		send_req(OP_READ, 8'h12, 4'h3, 4'h0, '0, '0, data, lat);
		check_count(rd_count - rd0, 1, "read miss rd_req count");
		check_addr(last_rd_addr, a, "read miss rd_addr");
		check_word(data, pattern_word(a, 0), "read miss data");
		check_count(wb_count - wb0, 0, "read miss wb_req count");
	endtask

	task automatic read_hit_reuse();
		cache_word_t data;
		int lat;
		int rd0;
		rd0 = rd_count;
		send_req(OP_READ, 8'h12, 4'h3, 4'h0, '0, '0, data, lat);
		check_count(lat, 1, "read hit latency");
		check_word(data, pattern_word({8'h12, 4'h3}, 0), "read hit data");
		check_count(rd_count - rd0, 0, "read hit rd_req count");
	endtask

	task automatic write_hit_strobe();
		cache_word_t data;
		int lat;
		int rd0;
		cache_word_t wdata;
		wdata = 64'h1111_2222_3333_4444;
		rd0 = rd_count;
		send_req(OP_WRITE, 8'h12, 4'h3, 4'h0, 8'h0f, wdata, data, lat);
		check_count(lat, 1, "write hit latency");
		send_req(OP_READ, 8'h12, 4'h3, 4'h0, '0, '0, data, lat);
		check_word(data, merge_bytes(pattern_word({8'h12, 4'h3}, 0), wdata, 8'h0f),
			"write hit merged bytes");
		check_count(rd_count - rd0, 0, "write hit rd_req count");
	endtask

	task automatic write_miss_alloc();
		cache_word_t data;
		int lat;
		int rd0;
		int wb0;
		mem_line_addr_t a;
		cache_word_t wdata;
		a = {8'h34, 4'h3};
		wdata = 64'haaaa_bbbb_cccc_dddd;
		rd0 = rd_count;
		wb0 = wb_count;
		// way 1 of set 3 is still invalid
		send_req(OP_WRITE, 8'h34, 4'h3, 4'h8, 8'hf0, wdata, data, lat);
		check_count(rd_count - rd0, 1, "write miss rd_req count");
		check_addr(last_rd_addr, a, "write miss rd_addr");
		check_count(wb_count - wb0, 0, "write miss wb_req count");
		send_req(OP_READ, 8'h34, 4'h3, 4'h8, '0, '0, data, lat);
		check_count(lat, 1, "write miss readback latency");
		check_word(data, merge_bytes(pattern_word(a, 1), wdata, 8'hf0), "write miss merged word");
		send_req(OP_READ, 8'h34, 4'h3, 4'h0, '0, '0, data, lat);
		check_word(data, pattern_word(a, 0), "write miss other word");
	endtask

	task automatic dirty_eviction();
		cache_word_t data;
		int lat;
		int rd0;
		int wb0;
		mem_line_addr_t a_addr;
		mem_line_addr_t c_addr;
		cache_word_t a_word;
		mem_line_t a_line;
		a_addr = {8'h5a, 4'h9};
		c_addr = {8'hc3, 4'h9};
		a_word = merge_bytes(pattern_word(a_addr, 0), 64'h0123_4567_89ab_cdef, 8'hc3);
		a_line = {pattern_word(a_addr, 1), a_word};
		wb0 = wb_count;
		// set 9 fills with dirty A in way 0 and clean B in way 1
		// two fills leave the pointer back at way 0
		send_req(OP_WRITE, 8'h5a, 4'h9, 4'h0, 8'hc3, 64'h0123_4567_89ab_cdef, data, lat);
		send_req(OP_READ, 8'h77, 4'h9, 4'h0, '0, '0, data, lat);
		check_count(wb_count - wb0, 0, "wb_req while set 9 fills");
		wb0 = wb_count;
		// C takes way 0 and pushes A out
		send_req(OP_READ, 8'hc3, 4'h9, 4'h8, '0, '0, data, lat);
		check_word(data, pattern_word(c_addr, 1), "eviction read data");
		check_count(wb_count - wb0, 1, "eviction wb_req count");
		check_addr(last_wb_addr, a_addr, "eviction wb_addr");
		check_line(last_wb_data, a_line, "eviction wb_data");
		wb0 = wb_count;
		rd0 = rd_count;
		// pointer on way 1 so clean B leaves without a write-back
		send_req(OP_READ, 8'h5a, 4'h9, 4'h0, '0, '0, data, lat);
		check_count(rd_count - rd0, 1, "re-read rd_req count");
		check_addr(last_rd_addr, a_addr, "re-read rd_addr");
		check_count(wb_count - wb0, 0, "re-read wb_req count");
		check_word(data, a_word, "re-read written-back data");
		// C still sits in way 0
		rd0 = rd_count;
		send_req(OP_READ, 8'hc3, 4'h9, 4'h8, '0, '0, data, lat);
		check_count(lat, 1, "resident line latency after re-read");
		check_count(rd_count - rd0, 0, "resident line rd_req count");
		check_word(data, pattern_word(c_addr, 1), "resident line data");
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, tests did not finish", $time);
		$display("Test failed");
		$finish;
	end

	initial begin
		int sva_fails;
		req_valid <= 1'b0;
		req_op <= OP_READ;
		req_tag <= '0;
		req_index <= '0;
		req_offset <= '0;
		req_wstrb <= '0;
		req_wdata <= '0;
		idle_after_reset();
		read_miss_alloc();
		read_hit_reuse();
		write_hit_strobe();
		write_miss_alloc();
		dirty_eviction();
		repeat (2) @(negedge clk);
		sva_fails = int'(cache_top_inst.cache_sva_inst.fail_count);
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, sva_fails);
		if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_consts.svh"

module cache_top (
	input wire logic clk,
	input wire logic rst,
	// processor side
	input wire logic req_valid,
	input cache_pkg::cache_op_e req_op,
	input wire logic [`CACHE_TAG_W-1:0] req_tag,
	input wire logic [`CACHE_INDEX_W-1:0] req_index,
	input wire logic [`CACHE_OFFSET_W-1:0] req_offset,
	input wire logic [`CACHE_STRB_W-1:0] req_wstrb,
	input wire logic [`CACHE_WORD_W-1:0] req_wdata,
	output logic addr_ok,
	output logic data_ok,
	output cache_pkg::cache_word_t rdata,
	// memory side
	output logic rd_req,
	output mem_pkg::mem_line_addr_t rd_addr,
	input wire logic rd_beat_valid,
	input wire logic rd_last,
	input cache_pkg::cache_word_t rd_data,
	output logic wb_req,
	output mem_pkg::mem_line_addr_t wb_addr,
	output mem_pkg::mem_line_t wb_data
);

	cache_pkg::cache_req_t miss_req;
	cache_pkg::cache_way_t miss_way;
	cache_pkg::cache_word_t miss_word;
	logic refill_start;
	logic refill_done;

	cache_array_if arr_if ();

	cache_storage cache_storage_inst (
		.clk (clk),
		.rst (rst),
		.arr (arr_if.storage)
	);

	cache_ctrl cache_ctrl_inst (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req_op       (req_op),
		.req_tag      (req_tag),
		.req_index    (req_index),
		.req_offset   (req_offset),
		.req_wstrb    (req_wstrb),
		.req_wdata    (req_wdata),
		.addr_ok      (addr_ok),
		.data_ok      (data_ok),
		.rdata        (rdata),
		.wb_req       (wb_req),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.miss_req     (miss_req),
		.miss_way     (miss_way),
		.refill_start (refill_start),
		.refill_done  (refill_done),
		.miss_word    (miss_word),
		.arr          (arr_if.ctrl)
	);

	cache_refill cache_refill_inst (
		.clk           (clk),
		.rst           (rst),
		.refill_start  (refill_start),
		.miss_req      (miss_req),
		.miss_way      (miss_way),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_beat_valid (rd_beat_valid),
		.rd_last       (rd_last),
		.rd_data       (rd_data),
		.refill_done   (refill_done),
		.miss_word     (miss_word),
		.arr           (arr_if.refill)
	);

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
cache_pkg.sv
mem_pkg.sv
cache_array_if.sv
cache_storage.sv
cache_ctrl.sv
cache_refill.sv
cache_top.sv
tb_clkgen.sv
cache_sva.sv
cache_tb.sv

// ==== mem_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package mem_pkg;

	// whole line, word 0 in the low bits
	typedef logic [`CACHE_BEATS*`CACHE_WORD_W-1:0] mem_line_t;

	// line address: tag then index, no offset
	typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] mem_line_addr_t;

endpackage

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// reset drops on a rising edge
	initial begin
		rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire
